/* Makefile */
SIM = obj_dir/Vvideo_frame_checker_tb

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module video_frame_checker_tb -f vlog.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qx 'test passed'

clean:
	rm -rf obj_dir

/* frame_signature.sv */
`timescale 1ns/1ps
`include "video_check_macros.svh"

module frame_signature (
  input  logic                        axi2hdmi_hsync_o,
  input  logic                        rst_n_i,
  input  logic                        frame_start_i,
  input  logic                        frame_done_i,
  input  logic                        pix_valid_i,
  input  video_check_pkg::pixel_t     pix_i,
  output video_check_pkg::sig_t       signature_o,
  output logic                        signature_valid_o,
  output video_check_pkg::frame_cnt_t frame_count_o
);

  import video_check_pkg::*;

  localparam int unsigned sig_w = $bits(sig_t);

  sig_t acc_q;
  sig_t acc_fold;
  sig_t acc_final;

  //////////////////////////////////////////////////////////////////////
  // Rotate-XOR accumulator
  //////////////////////////////////////////////////////////////////////

  // Rotate left by one, then mix in the new pixel
  assign acc_fold  = {acc_q[sig_w-2:0], acc_q[sig_w-1]} ^ pix_i;
  assign acc_final = pix_valid_i ? acc_fold : acc_q;

  // Frame start wins over a late pixel from an aborted frame
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (frame_start_i) begin
      acc_q <= `VC_SIG_SEED;
    end else begin
      acc_q <= acc_final;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Publication and frame count
  //////////////////////////////////////////////////////////////////////

  // Value published on frame_done already holds that edge's pixel
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (!rst_n_i) begin
      signature_o       <= '0;
      signature_valid_o <= 1'b0;
      frame_count_o     <= '0;
    end else begin
      signature_valid_o <= frame_done_i;
      if (frame_done_i) begin
        signature_o   <= acc_final;
        frame_count_o <= frame_count_o + 1'b1;
      end
    end
  end

endmodule

/* line_pixel_sampler.sv */
`timescale 1ns/1ps
`include "video_check_macros.svh"

module line_pixel_sampler (
  input  logic                    axi2hdmi_hsync_o,
  input  logic                    rst_n_i,
  input  logic                    line_active_i,
  input  logic [`VC_COLOR_W-1:0]  red_i,
  input  logic [`VC_COLOR_W-1:0]  green_i,
  input  logic [`VC_COLOR_W-1:0]  blue_i,
  output logic                    pix_valid_o,
  output video_check_pkg::pixel_t pix_o
);

  import video_check_pkg::*;

  pixel_t pix_packed;

  //////////////////////////////////////////////////////////////////////
  // Colour packing
  //////////////////////////////////////////////////////////////////////

  // Same byte order as the frame dumps of the HDMI monitor
  assign pix_packed = {blue_i, green_i, red_i};

  //////////////////////////////////////////////////////////////////////
  // One sample per active line
  //////////////////////////////////////////////////////////////////////

  // Valid flag follows line_active by one edge
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (!rst_n_i) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= line_active_i;
    end
  end

  // Pixel word only loads on active lines and holds otherwise
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (line_active_i) begin
      pix_o <= pix_packed;
    end
  end

endmodule

/* video_check_macros.svh */
`ifndef VIDEO_CHECK_MACROS_SVH
`define VIDEO_CHECK_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Pixel format
//////////////////////////////////////////////////////////////////////

// Bits per colour channel
`define VC_COLOR_W 8

//////////////////////////////////////////////////////////////////////
// Vertical timing of a 640x480 frame, in lines
//////////////////////////////////////////////////////////////////////

`define VC_VSYNC_LINES 2
`define VC_V_BACKPORCH 33
`define VC_ACT_Y 480

//////////////////////////////////////////////////////////////////////
// Signature
//////////////////////////////////////////////////////////////////////

// Value loaded into the accumulator at every frame start
`define VC_SIG_SEED 24'h000000

`endif

/* video_check_pkg.sv */
`include "video_check_macros.svh"

package video_check_pkg;

  // Vertical phase of the frame being tracked
  typedef enum logic [1:0] {
    V_IDLE,
    V_SYNC,
    V_BACK_PORCH,
    V_ACTIVE
  } v_phase_e;

  // Blue in the top byte, then green, red at the bottom
  typedef logic [3*`VC_COLOR_W-1:0] pixel_t;

  // Per-phase line counter, sized by the longest phase
  typedef logic [$clog2(`VC_ACT_Y)-1:0] line_cnt_t;

  // Rotate-XOR frame signature, same width as a pixel
  typedef logic [3*`VC_COLOR_W-1:0] sig_t;

  // Completed frames since reset
  typedef logic [15:0] frame_cnt_t;

endpackage

/* video_frame_checker.sv */
`timescale 1ns/1ps
`include "video_check_macros.svh"

module video_frame_checker (
  input  logic                        axi2hdmi_hsync_o,
  input  logic                        rst_n_i,
  input  logic                        axi2hdmi_vsync_i,
  input  logic [`VC_COLOR_W-1:0]      red_i,
  input  logic [`VC_COLOR_W-1:0]      green_i,
  input  logic [`VC_COLOR_W-1:0]      blue_i,
  output logic                        sync_err_o,
  output logic                        short_frame_err_o,
  output video_check_pkg::sig_t       signature_o,
  output logic                        signature_valid_o,
  output video_check_pkg::frame_cnt_t frame_count_o
);

  import video_check_pkg::*;

  // Tracker to sampler and signature
  logic   line_active;
  logic   frame_start;
  logic   frame_done;

  // Sampler to signature
  logic   pix_valid;
  pixel_t pix;

  //////////////////////////////////////////////////////////////////////
  // Vertical timing
  //////////////////////////////////////////////////////////////////////

  vsync_phase_tracker i_vsync_phase_tracker (
    .axi2hdmi_hsync_o  ( axi2hdmi_hsync_o  ),
    .rst_n_i           ( rst_n_i           ),
    .vsync_i           ( axi2hdmi_vsync_i  ),
    .line_active_o     ( line_active       ),
    .frame_start_o     ( frame_start       ),
    .frame_done_o      ( frame_done        ),
    .sync_err_o        ( sync_err_o        ),
    .short_frame_err_o ( short_frame_err_o )
  );

  //////////////////////////////////////////////////////////////////////
  // Pixel capture
  //////////////////////////////////////////////////////////////////////

  line_pixel_sampler i_line_pixel_sampler (
    .axi2hdmi_hsync_o ( axi2hdmi_hsync_o ),
    .rst_n_i          ( rst_n_i          ),
    .line_active_i    ( line_active      ),
    .red_i            ( red_i            ),
    .green_i          ( green_i          ),
    .blue_i           ( blue_i           ),
    .pix_valid_o      ( pix_valid        ),
    .pix_o            ( pix              )
  );

  //////////////////////////////////////////////////////////////////////
  // Frame signature
  //////////////////////////////////////////////////////////////////////

  frame_signature i_frame_signature (
    .axi2hdmi_hsync_o  ( axi2hdmi_hsync_o  ),
    .rst_n_i           ( rst_n_i           ),
    .frame_start_i     ( frame_start       ),
    .frame_done_i      ( frame_done        ),
    .pix_valid_i       ( pix_valid         ),
    .pix_i             ( pix               ),
    .signature_o       ( signature_o       ),
    .signature_valid_o ( signature_valid_o ),
    .frame_count_o     ( frame_count_o     )
  );

endmodule

/* video_frame_checker_tb.sv */
`timescale 1ns/1ps
`include "video_check_macros.svh"

module video_frame_checker_tb;

  import video_check_pkg::*;

  localparam int cw           = `VC_COLOR_W;
  localparam int sig_w        = $bits(sig_t);
  localparam int sync_edges   = `VC_VSYNC_LINES;
  // E35 is the first active line edge and E515 publishes the signature
  localparam int first_active = `VC_VSYNC_LINES + `VC_V_BACKPORCH;
  localparam int frame_edges  = first_active + `VC_ACT_Y;
  localparam int wait_limit   = 50;
  localparam int run_limit    = 20000;

  logic          axi2hdmi_hsync_o;
  logic          rst_n_i;
  logic          axi2hdmi_vsync_i;
  logic [cw-1:0] red_i;
  logic [cw-1:0] green_i;
  logic [cw-1:0] blue_i;
  logic          sync_err_o;
  logic          short_frame_err_o;
  sig_t          signature_o;
  logic          signature_valid_o;
  frame_cnt_t    frame_count_o;

  integer seed      = 32'he6e0_0105;
  int     edge_cnt  = 0;
  int     next_edge = 0;
  int     error_cnt = 0;
  int     tests_run = 0;
  int     tests_ok  = 0;

  // Strobe history with edges numbered from the first clock edge
  int     sync_err_seen  = 0;
  int     short_err_seen = 0;
  int     sig_seen       = 0;
  int     sync_err_edge  = 0;
  int     short_err_edge = 0;
  int     sig_edge       = 0;
  sig_t   sig_last       = '0;

  //////////////////////////////////////////////////////////////////////
  // Clock, edge count and DUT
  //////////////////////////////////////////////////////////////////////

  initial begin
    axi2hdmi_hsync_o = 1'b0;
    forever #4 axi2hdmi_hsync_o = ~axi2hdmi_hsync_o;
  end

  always @(posedge axi2hdmi_hsync_o) begin
    edge_cnt <= edge_cnt + 1;
  end

  video_frame_checker dut_i (
    .axi2hdmi_hsync_o  ( axi2hdmi_hsync_o  ),
    .rst_n_i           ( rst_n_i           ),
    .axi2hdmi_vsync_i  ( axi2hdmi_vsync_i  ),
    .red_i             ( red_i             ),
    .green_i           ( green_i           ),
    .blue_i            ( blue_i            ),
    .sync_err_o        ( sync_err_o        ),
    .short_frame_err_o ( short_frame_err_o ),
    .signature_o       ( signature_o       ),
    .signature_valid_o ( signature_valid_o ),
    .frame_count_o     ( frame_count_o     )
  );

  // All three strobes last a single cycle
  assert property (@(posedge axi2hdmi_hsync_o) disable iff (!rst_n_i)
                   signature_valid_o |=> !signature_valid_o)
    else begin
      error_cnt++;
      $display("signature_valid_o stayed high for more than one cycle");
    end

  assert property (@(posedge axi2hdmi_hsync_o) disable iff (!rst_n_i)
                   sync_err_o |=> !sync_err_o)
    else begin
      error_cnt++;
      $display("sync_err_o stayed high for more than one cycle");
    end

  assert property (@(posedge axi2hdmi_hsync_o) disable iff (!rst_n_i)
                   short_frame_err_o |=> !short_frame_err_o)
    else begin
      error_cnt++;
      $display("short_frame_err_o stayed high for more than one cycle");
    end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp)
      else begin
        error_cnt++;
        $display("error %s: got %h expected %h", name, got, exp);
      end
  endtask

  // Outputs seen at a falling edge belong to the rising edge before it
  task automatic record_strobes();
    if (sync_err_o) begin
      sync_err_seen++;
      sync_err_edge = edge_cnt;
    end
    if (short_frame_err_o) begin
      short_err_seen++;
      short_err_edge = edge_cnt;
    end
    if (signature_valid_o) begin
      sig_seen++;
      sig_edge = edge_cnt;
      sig_last = signature_o;
    end
  endtask

  // One line with fresh random colours
  task automatic drive_line(input logic vsync);
    logic [31:0] rnd;
    @(negedge axi2hdmi_hsync_o);
    record_strobes();
    rnd              = $random(seed);
    axi2hdmi_vsync_i = vsync;
    red_i            = rnd[0 +: cw];
    green_i          = rnd[cw +: cw];
    blue_i           = rnd[2*cw +: cw];
    next_edge        = edge_cnt + 1;
  endtask

  task automatic idle_lines(input int n);
    repeat (n) drive_line(1'b0);
  endtask

  task automatic apply_reset();
    rst_n_i          = 1'b0;
    axi2hdmi_vsync_i = 1'b0;
    repeat (8) @(posedge axi2hdmi_hsync_o);
    @(negedge axi2hdmi_hsync_o);
    rst_n_i = 1'b1;
  endtask

  // Drives a frame of the given length and folds the active line pixels
  task automatic drive_frame(input int vsync_lines, input int edges,
                             output sig_t model, output int e0);
    model = `VC_SIG_SEED;
    e0    = 0;
    for (int k = 0; k < edges; k++) begin
      drive_line(k < vsync_lines);
      if (k == 0) begin
        e0 = next_edge;
      end
      if (k >= first_active) begin
        model = {model[sig_w-2:0], model[sig_w-1]} ^ {blue_i, green_i, red_i};
      end
    end
  endtask

  task automatic wait_for_signature(input int prev);
    int n;
    n = 0;
    while (sig_seen == prev && n < wait_limit) begin
      drive_line(1'b0);
      n++;
    end
    if (sig_seen == prev) begin
      error_cnt++;
      $display("no signature_valid_o pulse within %0d lines", wait_limit);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_cnt == errs_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d failing checks", name, error_cnt - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    sig_t model;
    int   e0;
    int   errs;
    int   sync_before;
    int   short_before;
    int   sig_before;
    int   count_before;

    rst_n_i          = 1'b0;
    axi2hdmi_vsync_i = 1'b0;
    red_i            = '0;
    green_i          = '0;
    blue_i           = '0;
    apply_reset();

    errs = error_cnt;
    check_eq("sync_err_o", 32'(sync_err_o), 32'h0);
    check_eq("short_frame_err_o", 32'(short_frame_err_o), 32'h0);
    check_eq("signature_valid_o", 32'(signature_valid_o), 32'h0);
    check_eq("frame_count_o", 32'(frame_count_o), 32'h0);
    check_eq("signature_o", 32'(signature_o), 32'h0);
    finish_test("reset_values", errs);
    idle_lines(4);

    // Single well-formed frame
    errs         = error_cnt;
    sync_before  = sync_err_seen;
    short_before = short_err_seen;
    sig_before   = sig_seen;
    drive_frame(sync_edges, frame_edges, model, e0);
    wait_for_signature(sig_before);
    check_eq("signature_valid_o offset", 32'(sig_edge - e0), 32'(frame_edges));
    check_eq("signature_o", 32'(sig_last), 32'(model));
    check_eq("sync_err_o pulses", 32'(sync_err_seen - sync_before), 32'h0);
    check_eq("short_frame_err_o pulses", 32'(short_err_seen - short_before), 32'h0);
    check_eq("frame_count_o", 32'(frame_count_o), 32'h1);
    finish_test("single_frame", errs);
    idle_lines(8);

    // Three frames from a fresh reset
    errs = error_cnt;
    apply_reset();
    idle_lines(4);
    for (int f = 0; f < 3; f++) begin
      sig_before = sig_seen;
      drive_frame(sync_edges, frame_edges, model, e0);
      wait_for_signature(sig_before);
      check_eq("signature_o", 32'(sig_last), 32'(model));
      check_eq("frame_count_o", 32'(frame_count_o), 32'(f + 1));
      idle_lines(8);
    end
    check_eq("frame_count_o", 32'(frame_count_o), 32'h3);
    finish_test("three_frames", errs);

    // Sync held one line too long
    errs         = error_cnt;
    sync_before  = sync_err_seen;
    short_before = short_err_seen;
    sig_before   = sig_seen;
    drive_frame(sync_edges + 1, frame_edges, model, e0);
    wait_for_signature(sig_before);
    check_eq("sync_err_o pulses", 32'(sync_err_seen - sync_before), 32'h1);
    check_eq("sync_err_o offset", 32'(sync_err_edge - e0), 32'h2);
    check_eq("short_frame_err_o pulses", 32'(short_err_seen - short_before), 32'h0);
    check_eq("signature_valid_o offset", 32'(sig_edge - e0), 32'(frame_edges));
    check_eq("signature_o", 32'(sig_last), 32'(model));
    finish_test("long_sync", errs);
    idle_lines(8);

    // Frame cut short in the middle of the active lines
    errs         = error_cnt;
    short_before = short_err_seen;
    sig_before   = sig_seen;
    count_before = int'(frame_count_o);
    drive_frame(sync_edges, first_active + 160, model, e0);
    assert (sig_seen == sig_before)
      else begin
        error_cnt++;
        $display("signature_valid_o pulsed for a frame that was cut short");
      end
    drive_frame(sync_edges, frame_edges, model, e0);
    wait_for_signature(sig_before);
    check_eq("short_frame_err_o pulses", 32'(short_err_seen - short_before), 32'h1);
    check_eq("short_frame_err_o edge", 32'(short_err_edge), 32'(e0));
    check_eq("signature_valid_o pulses", 32'(sig_seen - sig_before), 32'h1);
    check_eq("signature_o", 32'(sig_last), 32'(model));
    check_eq("frame_count_o", 32'(frame_count_o), 32'(count_before + 1));
    finish_test("short_frame", errs);
    idle_lines(4);

    $display("tests run %0d, ok %0d, failing checks %0d", tests_run, tests_ok, error_cnt);
    if (error_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    int n;
    n = 0;
    while (n < run_limit) begin
      @(posedge axi2hdmi_hsync_o);
      n++;
    end
    $display("simulation did not finish within %0d cycles", run_limit);
    $display("test failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
video_check_pkg.sv
vsync_phase_tracker.sv
line_pixel_sampler.sv
frame_signature.sv
video_frame_checker.sv
video_frame_checker_tb.sv

/* vsync_phase_tracker.sv */
`timescale 1ns/1ps
`include "video_check_macros.svh"

module vsync_phase_tracker (
  input  logic axi2hdmi_hsync_o,
  input  logic rst_n_i,
  input  logic vsync_i,
  output logic line_active_o,
  output logic frame_start_o,
  output logic frame_done_o,
  output logic sync_err_o,
  output logic short_frame_err_o
);

  import video_check_pkg::*;

  // Last count value of each phase
  localparam line_cnt_t sync_last   = line_cnt_t'(`VC_VSYNC_LINES - 1);
  localparam line_cnt_t porch_last  = line_cnt_t'(`VC_V_BACKPORCH - 1);
  localparam line_cnt_t active_last = line_cnt_t'(`VC_ACT_Y - 1);

  logic      vsync_q;
  logic      vsync_rise;

  v_phase_e  phase_q;
  v_phase_e  phase_d;
  line_cnt_t line_cnt_q;
  line_cnt_t line_cnt_d;

  logic      frame_start_d;
  logic      frame_done_d;
  logic      sync_err_d;
  logic      short_err_d;

  //////////////////////////////////////////////////////////////////////
  // Vsync sampling and rise detection
  //////////////////////////////////////////////////////////////////////

  // A vsync already high at reset release does not open a frame
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (!rst_n_i) begin
      vsync_q <= 1'b1;
    end else begin
      vsync_q <= vsync_i;
    end
  end

  assign vsync_rise = vsync_i & ~vsync_q;

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  // The rise edge itself is the first sync line, so the count starts at 0
  // and the sync check lands on the first back porch line.
  // Back porch enters with a count of 1 since that edge is already a
  // porch line, and leaves one edge early so that the phase leads each
  // active line by one cycle
  always_comb begin
    phase_d       = phase_q;
    line_cnt_d    = line_cnt_q;
    frame_start_d = 1'b0;
    frame_done_d  = 1'b0;
    sync_err_d    = 1'b0;
    short_err_d   = 1'b0;

    if (vsync_rise) begin
      // New frame, possibly cutting the current one short
      short_err_d   = (phase_q != V_IDLE);
      phase_d       = V_SYNC;
      line_cnt_d    = '0;
      frame_start_d = 1'b1;
    end else begin
      case (phase_q)
        V_IDLE: begin
          line_cnt_d = '0;
        end
        V_SYNC: begin
          if (line_cnt_q == sync_last) begin
            phase_d    = V_BACK_PORCH;
            line_cnt_d = line_cnt_t'(1);
            // Sync should be gone by the first porch line
            sync_err_d = vsync_i;
          end else begin
            line_cnt_d = line_cnt_q + 1'b1;
          end
        end
        V_BACK_PORCH: begin
          if (line_cnt_q == porch_last) begin
            phase_d    = V_ACTIVE;
            line_cnt_d = '0;
          end else begin
            line_cnt_d = line_cnt_q + 1'b1;
          end
        end
        V_ACTIVE: begin
          if (line_cnt_q == active_last) begin
            phase_d      = V_IDLE;
            line_cnt_d   = '0;
            frame_done_d = 1'b1;
          end else begin
            line_cnt_d = line_cnt_q + 1'b1;
          end
        end
        default: begin
          phase_d    = V_IDLE;
          line_cnt_d = '0;
        end
      endcase
    end
  end

  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (!rst_n_i) begin
      phase_q           <= V_IDLE;
      line_cnt_q        <= '0;
      frame_start_o     <= 1'b0;
      frame_done_o      <= 1'b0;
      sync_err_o        <= 1'b0;
      short_frame_err_o <= 1'b0;
    end else begin
      phase_q           <= phase_d;
      line_cnt_q        <= line_cnt_d;
      frame_start_o     <= frame_start_d;
      frame_done_o      <= frame_done_d;
      sync_err_o        <= sync_err_d;
      short_frame_err_o <= short_err_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  // High during the cycle that ends on an active line edge
  assign line_active_o = (phase_q == V_ACTIVE);

endmodule
